//--- Makefile
# Verilator build and run of the wakeup pipeline testbench
# Override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= wakeupPipeTb
FILELIST  ?= wakeupPipe.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result line, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/flushWindow.sv
//////////////////////////////////////////////////
// Recovery bookkeeping for the wakeup pipeline.
// Latches the selective flush range and tracks,
// per lane, how long flushed ops may still exit.
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module flushWindow import schedulerPkg::*; (
    input  logic            clk,
    input  logic            arstN,
    input  logic            stall,

    // Recovery request
    input  logic            toRecoveryPhase,
    input  logic            recoveryFromRwStage,
    input  activeListIndexT flushRangeHeadPtr,
    input  activeListIndexT flushRangeTailPtr,
    input  logic            flushAllInsns,

    // Latched range for the lanes
    output activeListIndexT rangeHeadPtr,
    output activeListIndexT rangeTailPtr,
    output logic            rangeAll,

    // Lane controls
    output logic            recoveryClear,
    output logic            intWindowActive,
    output logic            memWindowActive,
    output logic            flushedOpExist
);

    logic       rwRecovery;
    logic [1:0] windowActive;

    // Register-write recovery flushes selectively, any other stage flushes everything
    assign rwRecovery    = toRecoveryPhase && recoveryFromRwStage;
    assign recoveryClear = toRecoveryPhase && !recoveryFromRwStage;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rangeHeadPtr <= '0;
            rangeTailPtr <= '0;
            rangeAll     <= 1'b0;
        end else if (rwRecovery) begin
            rangeHeadPtr <= flushRangeHeadPtr;
            rangeTailPtr <= flushRangeTailPtr;
            rangeAll     <= flushAllInsns;
        end
    end

    // One countdown per lane with index 0 for integer and 1 for memory
    for (genvar lane = 0; lane < 2; lane++) begin : gLaneWindow
        localparam flushCountT seed = (lane == 0) ? flushCountT'(intLatency)
                                                  : flushCountT'(memLatency);
        flushCountT count;

        always_ff @(posedge clk or negedge arstN) begin
            if (!arstN) begin
                count <= '0;
            end else if (rwRecovery) begin
                count <= seed;
            end else if (count == seed) begin
                // Entry stage holds under stall, so the first step waits for it
                if (!stall) begin
                    count <= count - 1'b1;
                end
            end else if (count != '0) begin
                count <= count - 1'b1;
            end
        end

        assign windowActive[lane] = (count != '0);
    end

    assign intWindowActive = windowActive[0];
    assign memWindowActive = windowActive[1];
    assign flushedOpExist  = |windowActive;

endmodule

`default_nettype wire

//--- hw/schedulerPkg.sv
//////////////////////////////////////////////////
// Scheduler sizes, vector types and the selective
// flush range check shared by the wakeup pipeline.
// Modules pull it in with a wildcard import.
//////////////////////////////////////////////////

`default_nettype none

package schedulerPkg;

    // Issue queue
    localparam int iqEntries = 16;
    typedef logic [$clog2(iqEntries)-1:0] iqIndexT;
    // One bit per issue-queue entry, used for producer vectors and flush masks
    typedef logic [iqEntries-1:0] iqOneHotT;

    // Active list
    localparam int activeListEntries = 32;
    typedef logic [$clog2(activeListEntries)-1:0] activeListIndexT;

    // Select slots, integer slots first, then the memory slot
    localparam int intIssueWidth = 2;
    localparam int memIssueWidth = 1;
    localparam int issueWidth = intIssueWidth + memIssueWidth;

    // Pipeline depth of each lane in cycles
    localparam int intLatency = 1;
    localparam int memLatency = 2;

    // Counter for how long flushed ops may still sit in a lane
    typedef logic [1:0] flushCountT;

    // True when ptr lies in [headPtr, tailPtr) on the circular active list,
    // or when every instruction is flushed
    function automatic logic inFlushRange(
        input activeListIndexT ptr,
        input activeListIndexT headPtr,
        input activeListIndexT tailPtr,
        input logic flushAll
    );
        logic hit;
        if (flushAll) begin
            hit = 1'b1;
        end else if (headPtr == tailPtr) begin
            // Empty range
            hit = 1'b0;
        end else if (headPtr < tailPtr) begin
            hit = (ptr >= headPtr) && (ptr < tailPtr);
        end else begin
            // Range wraps past the last entry
            hit = (ptr >= headPtr) || (ptr < tailPtr);
        end
        return hit;
    endfunction

endpackage

`default_nettype wire

//--- hw/wakeupLane.sv
//////////////////////////////////////////////////
// Pipeline registers of one wakeup lane. Admits
// selected ops, carries them laneLatency cycles and
// wakes consumers and frees entries on exit.
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module wakeupLane import schedulerPkg::*; #(
    parameter int laneLatency = intLatency,
    parameter int laneWidth   = intIssueWidth
) (
    input  logic                              clk,
    input  logic                              arstN,
    input  logic                              stall,
    input  logic                              recoveryClear,

    // From select logic
    input  logic            [laneWidth-1:0]   selected,
    input  iqIndexT         [laneWidth-1:0]   selectedPtr,
    input  iqOneHotT        [laneWidth-1:0]   selectedVector,
    input  activeListIndexT [laneWidth-1:0]   selectedActiveListPtr,
    input  iqOneHotT                          flushIqEntry,

    // Selective flush window
    input  logic                              windowActive,
    input  activeListIndexT                   rangeHeadPtr,
    input  activeListIndexT                   rangeTailPtr,
    input  logic                              rangeAll,

    // To the issue queue
    output logic            [laneWidth-1:0]   wakeup,
    output iqIndexT         [laneWidth-1:0]   wakeupPtr,
    output iqOneHotT        [laneWidth-1:0]   wakeupVector,
    output logic            [laneWidth-1:0]   releaseEntry,
    output iqIndexT         [laneWidth-1:0]   releasePtr
);

    // Stage laneLatency-1 is the entry stage, stage 0 the exit stage
    logic            stageValid         [laneWidth][laneLatency];
    iqIndexT         stagePtr           [laneWidth][laneLatency];
    iqOneHotT        stageDepVector     [laneWidth][laneLatency];
    activeListIndexT stageActiveListPtr [laneWidth][laneLatency];

    logic [laneWidth-1:0] admit;
    logic [laneWidth-1:0] exitFlush;
    logic                 gateByStall;

    // Drop ops whose issue-queue entry is flushed this cycle
    always_comb begin
        for (int i = 0; i < laneWidth; i++) begin
            admit[i] = selected[i] && !flushIqEntry[selectedPtr[i]];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < laneWidth; i++) begin
                for (int j = 0; j < laneLatency; j++) begin
                    stageValid[i][j] <= 1'b0;
                end
            end
        end else if (recoveryClear) begin
            for (int i = 0; i < laneWidth; i++) begin
                for (int j = 0; j < laneLatency; j++) begin
                    stageValid[i][j] <= 1'b0;
                end
            end
        end else if (!stall) begin
            for (int i = 0; i < laneWidth; i++) begin
                for (int j = 0; j < laneLatency - 1; j++) begin
                    stageValid[i][j] <= stageValid[i][j+1];
                end
                stageValid[i][laneLatency-1] <= admit[i];
            end
        end else begin
            // Entry stage holds, later stages drain with a bubble behind it
            for (int i = 0; i < laneWidth; i++) begin
                for (int j = 0; j < laneLatency - 1; j++) begin
                    if (j == laneLatency - 2) begin
                        stageValid[i][j] <= 1'b0;
                    end else begin
                        stageValid[i][j] <= stageValid[i][j+1];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < laneWidth; i++) begin
            if (!stall) begin
                for (int j = 0; j < laneLatency - 1; j++) begin
                    stagePtr[i][j]           <= stagePtr[i][j+1];
                    stageDepVector[i][j]     <= stageDepVector[i][j+1];
                    stageActiveListPtr[i][j] <= stageActiveListPtr[i][j+1];
                end
                stagePtr[i][laneLatency-1]           <= selectedPtr[i];
                stageDepVector[i][laneLatency-1]     <= selectedVector[i];
                stageActiveListPtr[i][laneLatency-1] <= selectedActiveListPtr[i];
            end else begin
                for (int j = 0; j < laneLatency - 1; j++) begin
                    if (j == laneLatency - 2) begin
                        // Bubble carries no producer bits
                        stageDepVector[i][j] <= '0;
                    end else begin
                        stagePtr[i][j]           <= stagePtr[i][j+1];
                        stageDepVector[i][j]     <= stageDepVector[i][j+1];
                        stageActiveListPtr[i][j] <= stageActiveListPtr[i][j+1];
                    end
                end
            end
        end
    end

    // A single-stage lane exits straight from the stalled register
    assign gateByStall = (laneLatency == 1) && stall;

    always_comb begin
        for (int i = 0; i < laneWidth; i++) begin
            exitFlush[i] = windowActive && inFlushRange(stageActiveListPtr[i][0],
                rangeHeadPtr, rangeTailPtr, rangeAll);
            wakeup[i]       = stageValid[i][0] && !exitFlush[i] && !gateByStall;
            wakeupPtr[i]    = stagePtr[i][0];
            wakeupVector[i] = gateByStall ? '0 : stageDepVector[i][0];
            // Flushed ops still free their entry
            releaseEntry[i] = stageValid[i][0] && !gateByStall;
            releasePtr[i]   = stagePtr[i][0];
        end
    end

endmodule

`default_nettype wire

//--- hw/wakeupPipeTop.sv
//////////////////////////////////////////////////
// Wakeup pipeline register of the scheduler. Splits
// the select slots into the integer and memory
// lanes and shares one recovery flush window.
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module wakeupPipeTop import schedulerPkg::*; (
    input  logic                              clk,
    input  logic                              arstN,
    input  logic                              stall,

    // Select slots
    input  logic            [issueWidth-1:0]  selected,
    input  iqIndexT         [issueWidth-1:0]  selectedPtr,
    input  iqOneHotT        [issueWidth-1:0]  selectedVector,
    input  activeListIndexT [issueWidth-1:0]  selectedActiveListPtr,

    // Recovery
    input  iqOneHotT                          flushIqEntry,
    input  logic                              toRecoveryPhase,
    input  logic                              recoveryFromRwStage,
    input  activeListIndexT                   flushRangeHeadPtr,
    input  activeListIndexT                   flushRangeTailPtr,
    input  logic                              flushAllInsns,

    // Wakeup and release
    output logic            [issueWidth-1:0]  wakeup,
    output iqIndexT         [issueWidth-1:0]  wakeupPtr,
    output iqOneHotT        [issueWidth-1:0]  wakeupVector,
    output logic            [issueWidth-1:0]  releaseEntry,
    output iqIndexT         [issueWidth-1:0]  releasePtr,
    output logic                              flushedOpExist
);

    activeListIndexT rangeHeadPtr;
    activeListIndexT rangeTailPtr;
    logic            rangeAll;
    logic            recoveryClear;
    logic            intWindowActive;
    logic            memWindowActive;

    flushWindow flushWindowInst (
        .clk                 (clk),
        .arstN               (arstN),
        .stall               (stall),
        .toRecoveryPhase     (toRecoveryPhase),
        .recoveryFromRwStage (recoveryFromRwStage),
        .flushRangeHeadPtr   (flushRangeHeadPtr),
        .flushRangeTailPtr   (flushRangeTailPtr),
        .flushAllInsns       (flushAllInsns),
        .rangeHeadPtr        (rangeHeadPtr),
        .rangeTailPtr        (rangeTailPtr),
        .rangeAll            (rangeAll),
        .recoveryClear       (recoveryClear),
        .intWindowActive     (intWindowActive),
        .memWindowActive     (memWindowActive),
        .flushedOpExist      (flushedOpExist)
    );

    // Slots 0 and 1
    wakeupLane #(
        .laneLatency (intLatency),
        .laneWidth   (intIssueWidth)
    ) intLane (
        .clk                   (clk),
        .arstN                 (arstN),
        .stall                 (stall),
        .recoveryClear         (recoveryClear),
        .selected              (selected[intIssueWidth-1:0]),
        .selectedPtr           (selectedPtr[intIssueWidth-1:0]),
        .selectedVector        (selectedVector[intIssueWidth-1:0]),
        .selectedActiveListPtr (selectedActiveListPtr[intIssueWidth-1:0]),
        .flushIqEntry          (flushIqEntry),
        .windowActive          (intWindowActive),
        .rangeHeadPtr          (rangeHeadPtr),
        .rangeTailPtr          (rangeTailPtr),
        .rangeAll              (rangeAll),
        .wakeup                (wakeup[intIssueWidth-1:0]),
        .wakeupPtr             (wakeupPtr[intIssueWidth-1:0]),
        .wakeupVector          (wakeupVector[intIssueWidth-1:0]),
        .releaseEntry          (releaseEntry[intIssueWidth-1:0]),
        .releasePtr            (releasePtr[intIssueWidth-1:0])
    );

    // Slot 2, loads only
    wakeupLane #(
        .laneLatency (memLatency),
        .laneWidth   (memIssueWidth)
    ) memLane (
        .clk                   (clk),
        .arstN                 (arstN),
        .stall                 (stall),
        .recoveryClear         (recoveryClear),
        .selected              (selected[issueWidth-1:intIssueWidth]),
        .selectedPtr           (selectedPtr[issueWidth-1:intIssueWidth]),
        .selectedVector        (selectedVector[issueWidth-1:intIssueWidth]),
        .selectedActiveListPtr (selectedActiveListPtr[issueWidth-1:intIssueWidth]),
        .flushIqEntry          (flushIqEntry),
        .windowActive          (memWindowActive),
        .rangeHeadPtr          (rangeHeadPtr),
        .rangeTailPtr          (rangeTailPtr),
        .rangeAll              (rangeAll),
        .wakeup                (wakeup[issueWidth-1:intIssueWidth]),
        .wakeupPtr             (wakeupPtr[issueWidth-1:intIssueWidth]),
        .wakeupVector          (wakeupVector[issueWidth-1:intIssueWidth]),
        .releaseEntry          (releaseEntry[issueWidth-1:intIssueWidth]),
        .releasePtr            (releasePtr[issueWidth-1:intIssueWidth])
    );

endmodule

`default_nettype wire

//--- test/wakeupPipeTb.sv
//////////////////////////////////////////////////
// Directed testbench for the wakeup pipeline.
// Each behavior runs as a task; mismatches are
// counted and summed up in one closing line.
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module wakeupPipeTb import schedulerPkg::*; ();

    // Tests take about 45 cycles, so this leaves a wide margin
    localparam int timeoutCycles = 400;

    logic                             clk;
    logic                             arstN;
    logic                             stall;
    logic            [issueWidth-1:0] selected;
    iqIndexT         [issueWidth-1:0] selectedPtr;
    iqOneHotT        [issueWidth-1:0] selectedVector;
    activeListIndexT [issueWidth-1:0] selectedActiveListPtr;
    iqOneHotT                         flushIqEntry;
    logic                             toRecoveryPhase;
    logic                             recoveryFromRwStage;
    activeListIndexT                  flushRangeHeadPtr;
    activeListIndexT                  flushRangeTailPtr;
    logic                             flushAllInsns;
    logic            [issueWidth-1:0] wakeup;
    iqIndexT         [issueWidth-1:0] wakeupPtr;
    iqOneHotT        [issueWidth-1:0] wakeupVector;
    logic            [issueWidth-1:0] releaseEntry;
    iqIndexT         [issueWidth-1:0] releasePtr;
    logic                             flushedOpExist;

    int          errorCount;
    int          checkCount;
    int          cycleCount;
    logic [31:0] rngState;
    iqIndexT     expPtr [issueWidth];
    iqOneHotT    expVec [issueWidth];

    wakeupPipeTop wakeupPipeTop_inst (
        .clk                   (clk),
        .arstN                 (arstN),
        .stall                 (stall),
        .selected              (selected),
        .selectedPtr           (selectedPtr),
        .selectedVector        (selectedVector),
        .selectedActiveListPtr (selectedActiveListPtr),
        .flushIqEntry          (flushIqEntry),
        .toRecoveryPhase       (toRecoveryPhase),
        .recoveryFromRwStage   (recoveryFromRwStage),
        .flushRangeHeadPtr     (flushRangeHeadPtr),
        .flushRangeTailPtr     (flushRangeTailPtr),
        .flushAllInsns         (flushAllInsns),
        .wakeup                (wakeup),
        .wakeupPtr             (wakeupPtr),
        .wakeupVector          (wakeupVector),
        .releaseEntry          (releaseEntry),
        .releasePtr            (releasePtr),
        .flushedOpExist        (flushedOpExist)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Inputs change 1 ns after the edge, back to idle values
    task automatic nextCycle();
        @(posedge clk);
        #1;
        stall               = 1'b0;
        selected            = '0;
        flushIqEntry        = '0;
        toRecoveryPhase     = 1'b0;
        recoveryFromRwStage = 1'b0;
        flushAllInsns       = 1'b0;
    endtask

    // Outputs are sampled well before the next edge
    task automatic settle();
        #2;
    endtask

    // Random op on one slot; remembers what should come out
    task automatic drawOp(input int slot);
        rngState = xorshift32(rngState);
        selected[slot]              = 1'b1;
        selectedPtr[slot]           = rngState[3:0];
        selectedActiveListPtr[slot] = rngState[8:4];
        selectedVector[slot]        = rngState[31:16];
        expPtr[slot]                = rngState[3:0];
        expVec[slot]                = rngState[31:16];
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[FAIL] %0t ns: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic checkSlot(input int slot, input logic expWake, input logic expRel,
                             input string what);
        checkValue(32'(wakeup[slot]), 32'(expWake), {what, ": wakeup"});
        checkValue(32'(releaseEntry[slot]), 32'(expRel), {what, ": releaseEntry"});
        if (expRel) begin
            checkValue(32'(releasePtr[slot]), 32'(expPtr[slot]), {what, ": releasePtr"});
        end
        if (expWake) begin
            checkValue(32'(wakeupPtr[slot]), 32'(expPtr[slot]), {what, ": wakeupPtr"});
            checkValue(32'(wakeupVector[slot]), 32'(expVec[slot]), {what, ": wakeupVector"});
        end
    endtask

    task automatic checkIdle(input string what);
        checkValue(32'(wakeup), 32'd0, {what, ": wakeup"});
        checkValue(32'(releaseEntry), 32'd0, {what, ": releaseEntry"});
    endtask

    task automatic testIntWakeup();
        for (int n = 0; n < 4; n++) begin
            nextCycle();
            drawOp(0);
            drawOp(1);
            nextCycle();
            settle();
            checkSlot(0, 1'b1, 1'b1, "int wakeup slot 0");
            checkSlot(1, 1'b1, 1'b1, "int wakeup slot 1");
        end
    endtask

    task automatic testMemPipeline();
        iqIndexT  firstPtr;
        iqOneHotT firstVec;
        nextCycle();
        drawOp(2);
        firstPtr = expPtr[2];
        firstVec = expVec[2];
        nextCycle();
        drawOp(2);
        settle();
        checkSlot(2, 1'b0, 1'b0, "load still in stage 1");
        nextCycle();
        settle();
        checkValue(32'(wakeup[2]), 32'd1, "first load: wakeup");
        checkValue(32'(wakeupPtr[2]), 32'(firstPtr), "first load: wakeupPtr");
        checkValue(32'(wakeupVector[2]), 32'(firstVec), "first load: wakeupVector");
        nextCycle();
        settle();
        checkSlot(2, 1'b1, 1'b1, "second load");
    endtask

    task automatic testAdmissionFilter();
        nextCycle();
        drawOp(0);
        drawOp(1);
        drawOp(2);
        selectedPtr[0] = 4'd3;
        selectedPtr[1] = 4'd7;
        expPtr[1]      = 4'd7;
        selectedPtr[2] = 4'd3;
        flushIqEntry   = 16'h0008;
        nextCycle();
        settle();
        checkSlot(0, 1'b0, 1'b0, "filtered int op");
        checkSlot(1, 1'b1, 1'b1, "admitted int op");
        nextCycle();
        settle();
        checkIdle("filtered load");
    endtask

    // One register-write recovery; the range wraps from 28 to 6
    task automatic recoverAndSelect(input logic flushAll);
        nextCycle();
        toRecoveryPhase     = 1'b1;
        recoveryFromRwStage = 1'b1;
        flushAllInsns       = flushAll;
        flushRangeHeadPtr   = 5'd28;
        flushRangeTailPtr   = 5'd6;
        drawOp(0);
        drawOp(1);
        drawOp(2);
        selectedActiveListPtr[0] = 5'd30;
        selectedActiveListPtr[1] = 5'd6;
        selectedActiveListPtr[2] = 5'd2;
    endtask

    task automatic testSelectiveFlush();
        recoverAndSelect(1'b0);
        nextCycle();
        settle();
        checkValue(32'(flushedOpExist), 32'd1, "flushedOpExist after recovery");
        checkSlot(0, 1'b0, 1'b1, "in-range int op");
        checkSlot(1, 1'b1, 1'b1, "int op at the tail");
        nextCycle();
        settle();
        checkValue(32'(flushedOpExist), 32'd1, "flushedOpExist on memory window");
        checkSlot(2, 1'b0, 1'b1, "in-range load");
        nextCycle();
        settle();
        checkValue(32'(flushedOpExist), 32'd0, "flushedOpExist after windows");
        recoverAndSelect(1'b1);
        nextCycle();
        settle();
        checkSlot(0, 1'b0, 1'b1, "flush all int slot 0");
        checkSlot(1, 1'b0, 1'b1, "flush all int slot 1");
        nextCycle();
        settle();
        checkSlot(2, 1'b0, 1'b1, "flush all load");
        // Old range no longer applies once the window closed
        nextCycle();
        drawOp(0);
        selectedActiveListPtr[0] = 5'd30;
        nextCycle();
        settle();
        checkValue(32'(flushedOpExist), 32'd0, "flushedOpExist after flush all");
        checkSlot(0, 1'b1, 1'b1, "int op after window");
    endtask

    task automatic testFullRecovery();
        nextCycle();
        drawOp(2);
        nextCycle();
        toRecoveryPhase = 1'b1;
        drawOp(0);
        drawOp(1);
        for (int n = 0; n < 3; n++) begin
            nextCycle();
            settle();
            checkIdle("after full recovery");
        end
    endtask

    task automatic testStall();
        nextCycle();
        drawOp(0);
        nextCycle();
        stall = 1'b1;
        settle();
        checkIdle("int lane under stall");
        checkValue(32'(wakeupVector[0]), 32'd0, "int wakeupVector under stall");
        nextCycle();
        settle();
        checkSlot(0, 1'b1, 1'b1, "int op after stall");
        nextCycle();
        drawOp(2);
        settle();
        checkSlot(0, 1'b0, 1'b0, "int lane drained");
        nextCycle();
        stall = 1'b1;
        nextCycle();
        settle();
        checkSlot(2, 1'b0, 1'b0, "bubble behind stalled load");
        nextCycle();
        settle();
        checkSlot(2, 1'b1, 1'b1, "delayed load");
    endtask

    initial begin
        clk                   = 1'b0;
        arstN                 = 1'b0;
        stall                 = 1'b0;
        selected              = '0;
        selectedPtr           = '0;
        selectedVector        = '0;
        selectedActiveListPtr = '0;
        flushIqEntry          = '0;
        toRecoveryPhase       = 1'b0;
        recoveryFromRwStage   = 1'b0;
        flushRangeHeadPtr     = '0;
        flushRangeTailPtr     = '0;
        flushAllInsns         = 1'b0;
        errorCount            = 0;
        checkCount            = 0;
        cycleCount            = 0;
        rngState              = 32'h0f4a_8413;
        repeat (2) @(posedge clk);
        #1;
        arstN = 1'b1;
        settle();
        checkIdle("after reset");
        checkValue(32'(flushedOpExist), 32'd0, "flushedOpExist after reset");
        testIntWakeup();
        testMemPipeline();
        testAdmissionFilter();
        testSelectiveFlush();
        testFullRecovery();
        testStall();
        nextCycle();
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/wakeupPipe_sva.sv
//////////////////////////////////////////////////
// Concurrent checks on the wakeup pipeline top
// level, attached by the bind at the end.
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module wakeupPipeSva import schedulerPkg::*; (
    input logic                  clk,
    input logic                  arstN,
    input logic [issueWidth-1:0] wakeup,
    input logic [issueWidth-1:0] releaseEntry,
    input logic                  flushedOpExist
);

    // Integer lane exits straight from its only register
    latencyIsOne: assert property (@(posedge clk) intLatency == 1)
        else $error("integer lane latency is %0d, not 1", intLatency);

    // A wakeup always frees its own entry
    wakeupHasRelease: assert property (@(posedge clk) disable iff (!arstN)
        (wakeup & ~releaseEntry) == '0)
        else $error("wakeup without release: wakeup %b, release %b", wakeup, releaseEntry);

    // No flush window is open straight out of reset
    quietAfterReset: assert property (@(posedge clk) $rose(arstN) |-> !flushedOpExist)
        else $error("flushedOpExist high in the first cycle after reset");

endmodule

bind wakeupPipeTop wakeupPipeSva wakeupPipeSvaInst (
    .clk            (clk),
    .arstN          (arstN),
    .wakeup         (wakeup),
    .releaseEntry   (releaseEntry),
    .flushedOpExist (flushedOpExist)
);

`default_nettype wire

//--- wakeupPipe.f
hw/schedulerPkg.sv
hw/flushWindow.sv
hw/wakeupLane.sv
hw/wakeupPipeTop.sv
test/wakeupPipe_sva.sv
test/wakeupPipeTb.sv
